//--- i2c_master_ctrl.f
i2c_master_pkg.sv
i2c_ctrl_if.sv
i2c_phase_fsm.sv
i2c_cond_timer.sv
i2c_master_ctrl.sv
i2c_master_ctrl_properties.sv
tb_i2c_master_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_master_ctrl
RTL_TOP   ?= i2c_master_ctrl
FLIST     ?= i2c_master_ctrl.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- tb_i2c_master_ctrl.sv
`timescale 1ns/1ps

module tb_i2c_master_ctrl;
    import i2c_master_pkg::*;

    localparam int N_XFER      = 30;
    localparam int CYCLE_LIMIT = N_XFER * (9 * 10 * 4 + 64) * 2;  // worst transfer, doubled

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        rw;
    logic        sda;
    logic        rep;
    logic        tfe;
    logic        rff;
    logic [7:0]  done_time;
    logic [7:0]  edge_cnt;
    logic [7:0]  bit_cnt;
    logic [7:0]  presc;
    logic [11:0] dut_out;
    logic [11:0] exp_out;
    logic [31:0] lfsr;
    logic        rand_on;
    int          errors;
    int          cycles;
    int          xfers;

    // reference model state
    i2c_state_e  m_state;
    i2c_state_e  m_prev;
    i2c_state_e  nxt;
    logic [7:0]  m_cnt;
    logic        m_seen;
    logic        m_rd;
    logic        m_wr;
    logic        m_tick;
    logic        m_entry;
    logic        m_done;
    logic        m_rel;

    i2c_master_ctrl #(.COUNT_W(8)) dut0 (
        .i2c_core_clock_i      (clk),
        .reset_bit_n_i         (rst_n),
        .enable_bit_i          (en),
        .rw_bit_i              (rw),
        .sda_i                 (sda),
        .repeat_start_bit_i    (rep),
        .trans_fifo_empty_i    (tfe),
        .rev_fifo_full_i       (rff),
        .state_done_time_i     (done_time),
        .counter_detect_edge_i (edge_cnt),
        .counter_data_ack_i    (bit_cnt),
        .prescaler_i           (presc),
        .start_cnt_o           (dut_out[11]),
        .write_addr_cnt_o      (dut_out[10]),
        .write_data_cnt_o      (dut_out[9]),
        .read_data_cnt_o       (dut_out[8]),
        .write_ack_cnt_o       (dut_out[7]),
        .read_ack_cnt_o        (dut_out[6]),
        .stop_cnt_o            (dut_out[5]),
        .repeat_start_cnt_o    (dut_out[4]),
        .write_fifo_en_o       (dut_out[3]),
        .read_fifo_en_o        (dut_out[2]),
        .scl_en_o              (dut_out[1]),
        .sda_en_o              (dut_out[0])
    );

    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);  // galois step
        return lfsr[0];
    endfunction

    function automatic i2c_state_e next_phase(input i2c_state_e st);
        i2c_state_e fin;
        logic       last;
        logic       ack;
        fin  = rep ? ST_REPEAT_START : ST_STOP;
        last = m_tick && (bit_cnt == 8'd1);
        ack  = m_tick && (bit_cnt == 8'd0);
        case (st)
            ST_IDLE:         return (en && m_done) ? ST_START : st;
            ST_START:        return m_done ? ST_ADDR : st;
            ST_ADDR:         return last ? ST_ADDR_ACK : st;
            ST_ADDR_ACK:     return !ack ? st : sda ? fin : rw ? ST_READ_DATA : ST_WRITE_DATA;
            ST_WRITE_DATA:   return last ? ST_SLAVE_ACK : st;
            ST_SLAVE_ACK:    return !ack ? st : (sda || tfe) ? fin : ST_WRITE_DATA;
            ST_READ_DATA:    return last ? ST_MASTER_ACK : st;
            ST_MASTER_ACK: begin
                if (!(m_tick && (bit_cnt == 8'd9)))
                    return st;
                return rff ? fin : ST_READ_DATA;
            end
            ST_REPEAT_START: return m_done ? ST_ADDR : st;
            ST_STOP:         return m_done ? ST_IDLE : st;
            default:         return ST_IDLE;
        endcase
    endfunction

    // expected outputs in the same order as dut_out
    function automatic logic [11:0] expected_outputs(input i2c_state_e st, input logic rel);
        logic sda_e;
        logic scl_e;
        sda_e = st inside {ST_START, ST_ADDR, ST_WRITE_DATA, ST_MASTER_ACK,
                           ST_REPEAT_START, ST_STOP};
        scl_e = st inside {ST_ADDR, ST_ADDR_ACK, ST_WRITE_DATA, ST_READ_DATA,
                           ST_SLAVE_ACK, ST_MASTER_ACK};
        if (st == ST_STOP || st == ST_REPEAT_START)
            scl_e = !rel;                                        // scl freed after first tick
        return {st == ST_START, st == ST_ADDR, st == ST_WRITE_DATA, st == ST_READ_DATA,
                st == ST_MASTER_ACK, st == ST_ADDR_ACK || st == ST_SLAVE_ACK,
                st == ST_STOP, st == ST_REPEAT_START, m_wr, m_rd, scl_e, sda_e};
    endfunction

    // port name of each dut_out bit
    function automatic string output_name(input int idx);
        case (idx)
            11:      return "start_cnt_o";
            10:      return "write_addr_cnt_o";
            9:       return "write_data_cnt_o";
            8:       return "read_data_cnt_o";
            7:       return "write_ack_cnt_o";
            6:       return "read_ack_cnt_o";
            5:       return "stop_cnt_o";
            4:       return "repeat_start_cnt_o";
            3:       return "write_fifo_en_o";
            2:       return "read_fifo_en_o";
            1:       return "scl_en_o";
            default: return "sda_en_o";
        endcase
    endfunction

    assign m_tick  = (edge_cnt == presc);
    assign m_entry = (m_state != m_prev);
    assign m_done  = (m_cnt == 8'd0) && !m_entry;
    assign m_rel   = m_seen && !m_entry;

    // ------------------------------------------------------------
    // clock and cycle limit
    // ------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, only %0d of %0d transfers finished, errors %0d",
                     xfers, N_XFER, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_state <= ST_IDLE;
            m_prev  <= ST_IDLE;
            m_cnt   <= 8'd0;
            m_seen  <= 1'b0;
            m_rd    <= 1'b0;
            m_wr    <= 1'b0;
        end else begin
            nxt = next_phase(m_state);
            m_rd <= (m_state == ST_WRITE_DATA) && (nxt == ST_SLAVE_ACK);
            m_wr <= (m_state == ST_READ_DATA) && (nxt == ST_MASTER_ACK);
            if (m_entry)
                m_cnt <= (m_state == ST_REPEAT_START) ? presc + 8'd1 : done_time;
            else if (m_state == ST_IDLE)
                m_cnt <= !en ? done_time : (m_cnt != 8'd0) ? m_cnt - 8'd1 : m_cnt;
            else if (m_state inside {ST_START, ST_STOP, ST_REPEAT_START} && m_tick &&
                     m_cnt != 8'd0)
                m_cnt <= m_cnt - 8'd1;
            m_seen <= m_tick ? 1'b1 : m_entry ? 1'b0 : m_seen;
            if (nxt != m_state && (nxt == ST_STOP || nxt == ST_REPEAT_START))
                xfers++;                                         // transfer ended
            m_prev  <= m_state;
            m_state <= nxt;
        end
    end

    // ------------------------------------------------------------
    // stimulus, edge counter and bit counter
    // ------------------------------------------------------------
    always @(posedge clk) begin
        #1;
        if (m_state != m_prev && m_state inside {ST_ADDR, ST_WRITE_DATA, ST_READ_DATA})
            bit_cnt = 8'd9;                                      // new byte starts
        else if (edge_cnt == presc)
            bit_cnt = (bit_cnt == 8'd0) ? 8'd9 : bit_cnt - 8'd1;
        edge_cnt = (edge_cnt == presc) ? 8'd0 : edge_cnt + 8'd1;
        if (rand_on) begin
            en  = take_bit() | take_bit();
            rw  = take_bit();
            sda = take_bit() & take_bit();                       // mostly acked
            rep = take_bit() & take_bit();
            tfe = take_bit() & take_bit();
            rff = take_bit() & take_bit();
        end
    end

    // compare in the middle of the cycle
    always @(negedge clk) begin
        exp_out = expected_outputs(m_state, m_rel);
        for (int i = 0; i < 12; i++) begin
            if (dut_out[i] !== exp_out[i]) begin
                errors++;
                $display("ERR %0t %s expected %b actual %b",
                         $time, output_name(i), exp_out[i], dut_out[i]);
            end
        end
    end

    initial begin
        lfsr      = 32'hae715ea8;
        rst_n     = 1'b0;
        en        = 1'b0;
        rw        = 1'b0;
        sda       = 1'b0;
        rep       = 1'b0;
        tfe       = 1'b0;
        rff       = 1'b0;
        done_time = 8'd3;
        presc     = 8'd3;
        edge_cnt  = 8'd0;
        bit_cnt   = 8'd9;
        rand_on   = 1'b0;
        errors    = 0;
        cycles    = 0;
        xfers     = 0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (20) @(posedge clk);                              // idle with enable low
        rand_on = 1'b1;
        wait (xfers >= N_XFER);
        repeat (4) @(posedge clk);
        $display("transfers %0d, errors %0d", xfers, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- i2c_master_ctrl_properties.sv
`timescale 1ns/1ps

module i2c_master_ctrl_properties (
    input logic i2c_core_clock_i,
    input logic reset_bit_n_i,
    input logic start_cnt_o,
    input logic write_addr_cnt_o,
    input logic write_data_cnt_o,
    input logic read_data_cnt_o,
    input logic write_ack_cnt_o,
    input logic read_ack_cnt_o,
    input logic stop_cnt_o,
    input logic repeat_start_cnt_o,
    input logic write_fifo_en_o,
    input logic read_fifo_en_o
);

    // ------------------------------------------------------------
    // phase strobes are one-hot or all low
    // ------------------------------------------------------------
    a_phase_onehot: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        $onehot0({start_cnt_o, write_addr_cnt_o, write_data_cnt_o, read_data_cnt_o,
                  write_ack_cnt_o, read_ack_cnt_o, stop_cnt_o, repeat_start_cnt_o}))
        else $error("more than one phase strobe high");

    a_rd_fifo_pulse: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        read_fifo_en_o |=> !read_fifo_en_o)
        else $error("read_fifo_en_o longer than one cycle");

    a_wr_fifo_pulse: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        write_fifo_en_o |=> !write_fifo_en_o)
        else $error("write_fifo_en_o longer than one cycle");

    // pop only at the start of the slave ack slot
    a_rd_fifo_in_ack: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        $rose(read_fifo_en_o) |-> read_ack_cnt_o)
        else $error("read_fifo_en_o rose outside an ack-read phase");

endmodule

bind i2c_master_ctrl i2c_master_ctrl_properties props0 (
    .i2c_core_clock_i   (i2c_core_clock_i),
    .reset_bit_n_i      (reset_bit_n_i),
    .start_cnt_o        (start_cnt_o),
    .write_addr_cnt_o   (write_addr_cnt_o),
    .write_data_cnt_o   (write_data_cnt_o),
    .read_data_cnt_o    (read_data_cnt_o),
    .write_ack_cnt_o    (write_ack_cnt_o),
    .read_ack_cnt_o     (read_ack_cnt_o),
    .stop_cnt_o         (stop_cnt_o),
    .repeat_start_cnt_o (repeat_start_cnt_o),
    .write_fifo_en_o    (write_fifo_en_o),
    .read_fifo_en_o     (read_fifo_en_o)
);

//--- i2c_master_ctrl.sv
`timescale 1ns/1ps

module i2c_master_ctrl #(
    parameter int COUNT_W = 8
) (
    input  logic               i2c_core_clock_i,
    input  logic               reset_bit_n_i,

    // command and status levels
    input  logic               enable_bit_i,
    input  logic               rw_bit_i,
    input  logic               sda_i,
    input  logic               repeat_start_bit_i,
    input  logic               trans_fifo_empty_i,
    input  logic               rev_fifo_full_i,

    // counts from the clock generator and datapath
    input  logic [COUNT_W-1:0] state_done_time_i,
    input  logic [COUNT_W-1:0] counter_detect_edge_i,
    input  logic [COUNT_W-1:0] counter_data_ack_i,
    input  logic [COUNT_W-1:0] prescaler_i,

    // phase strobes
    output logic               start_cnt_o,
    output logic               write_addr_cnt_o,
    output logic               write_data_cnt_o,
    output logic               read_data_cnt_o,
    output logic               write_ack_cnt_o,
    output logic               read_ack_cnt_o,
    output logic               stop_cnt_o,
    output logic               repeat_start_cnt_o,

    output logic               write_fifo_en_o,  // push a received byte
    output logic               read_fifo_en_o,   // pop the next byte to send
    output logic               scl_en_o,
    output logic               sda_en_o
);

    i2c_ctrl_if #(.COUNT_W(COUNT_W)) ctrl_if ();

    i2c_phase_fsm #(
        .COUNT_W (COUNT_W)
    ) u_phase_fsm (
        .i2c_core_clock_i   (i2c_core_clock_i),
        .reset_bit_n_i      (reset_bit_n_i),
        .enable_bit_i       (enable_bit_i),
        .rw_bit_i           (rw_bit_i),
        .sda_i              (sda_i),
        .repeat_start_bit_i (repeat_start_bit_i),
        .trans_fifo_empty_i (trans_fifo_empty_i),
        .rev_fifo_full_i    (rev_fifo_full_i),
        .counter_data_ack_i (counter_data_ack_i),
        .ctrl               (ctrl_if.fsm_mp),
        .start_cnt_o        (start_cnt_o),
        .write_addr_cnt_o   (write_addr_cnt_o),
        .write_data_cnt_o   (write_data_cnt_o),
        .read_data_cnt_o    (read_data_cnt_o),
        .write_ack_cnt_o    (write_ack_cnt_o),
        .read_ack_cnt_o     (read_ack_cnt_o),
        .stop_cnt_o         (stop_cnt_o),
        .repeat_start_cnt_o (repeat_start_cnt_o),
        .write_fifo_en_o    (write_fifo_en_o),
        .read_fifo_en_o     (read_fifo_en_o),
        .scl_en_o           (scl_en_o),
        .sda_en_o           (sda_en_o)
    );

    i2c_cond_timer #(
        .COUNT_W (COUNT_W)
    ) u_cond_timer (
        .i2c_core_clock_i      (i2c_core_clock_i),
        .reset_bit_n_i         (reset_bit_n_i),
        .enable_bit_i          (enable_bit_i),
        .state_done_time_i     (state_done_time_i),
        .prescaler_i           (prescaler_i),
        .counter_detect_edge_i (counter_detect_edge_i),
        .ctrl                  (ctrl_if.timer_mp)
    );

endmodule

//--- i2c_cond_timer.sv
`timescale 1ns/1ps

module i2c_cond_timer
    import i2c_master_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  logic               i2c_core_clock_i,
    input  logic               reset_bit_n_i,
    input  logic               enable_bit_i,
    input  logic [COUNT_W-1:0] state_done_time_i,
    input  logic [COUNT_W-1:0] prescaler_i,
    input  logic [COUNT_W-1:0] counter_detect_edge_i,

    i2c_ctrl_if.timer_mp       ctrl
);

    i2c_state_e         prev_state_q;
    logic               state_entry;     // first cycle of a new state
    logic [COUNT_W-1:0] done_cnt_q;      // start/stop/repeat-start duration
    logic               tick_seen_q;

    assign ctrl.bit_tick = (counter_detect_edge_i == prescaler_i);
    assign state_entry   = (ctrl.state != prev_state_q);

    // the counter is reloaded during the entry cycle, so no done there
    assign ctrl.cond_done    = (done_cnt_q == '0) && !state_entry;
    assign ctrl.scl_released = tick_seen_q && !state_entry;

    // ------------------------------------------------------------
    // state entry detect
    // ------------------------------------------------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            prev_state_q <= ST_IDLE;
        end else begin
            prev_state_q <= ctrl.state;
        end
    end

    // ------------------------------------------------------------
    // duration counter
    // ------------------------------------------------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            done_cnt_q <= '0;
        end else if (state_entry) begin
            if (ctrl.state == ST_REPEAT_START)
                done_cnt_q <= prescaler_i + COUNT_W'(1);
            else
                done_cnt_q <= state_done_time_i;
        end else begin
            case (ctrl.state)
                ST_IDLE: begin
                    if (!enable_bit_i)
                        done_cnt_q <= state_done_time_i;         // hold off until enabled
                    else if (done_cnt_q != '0)
                        done_cnt_q <= done_cnt_q - COUNT_W'(1);
                end
                ST_START, ST_STOP, ST_REPEAT_START: begin
                    if (ctrl.bit_tick && (done_cnt_q != '0))
                        done_cnt_q <= done_cnt_q - COUNT_W'(1);  // one step per bit slot
                end
                default: ;
            endcase
        end
    end

    // scl release flag, set by any tick after state entry
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            tick_seen_q <= 1'b0;
        end else if (ctrl.bit_tick) begin
            tick_seen_q <= 1'b1;
        end else if (state_entry) begin
            tick_seen_q <= 1'b0;
        end
    end

endmodule

//--- i2c_phase_fsm.sv
`timescale 1ns/1ps

module i2c_phase_fsm
    import i2c_master_pkg::*;
#(
    parameter int COUNT_W = 8
) (
    input  logic               i2c_core_clock_i,
    input  logic               reset_bit_n_i,
    input  logic               enable_bit_i,
    input  logic               rw_bit_i,
    input  logic               sda_i,
    input  logic               repeat_start_bit_i,
    input  logic               trans_fifo_empty_i,
    input  logic               rev_fifo_full_i,
    input  logic [COUNT_W-1:0] counter_data_ack_i,

    i2c_ctrl_if.fsm_mp         ctrl,

    output logic               start_cnt_o,
    output logic               write_addr_cnt_o,
    output logic               write_data_cnt_o,
    output logic               read_data_cnt_o,
    output logic               write_ack_cnt_o,
    output logic               read_ack_cnt_o,
    output logic               stop_cnt_o,
    output logic               repeat_start_cnt_o,
    output logic               write_fifo_en_o,
    output logic               read_fifo_en_o,
    output logic               scl_en_o,
    output logic               sda_en_o
);

    i2c_state_e state_q;
    i2c_state_e state_d;
    i2c_state_e end_state;      // where a finished transfer goes
    logic       last_bit;       // last bit slot of a byte, on a tick
    logic       ack_sample;     // slave ack slot, on a tick
    logic       mack_end;       // end of master ack slot, on a tick

    assign last_bit   = ctrl.bit_tick && (counter_data_ack_i == COUNT_W'(LAST_BIT_CNT));
    assign ack_sample = ctrl.bit_tick && (counter_data_ack_i == COUNT_W'(ACK_SAMPLE_CNT));
    assign mack_end   = ctrl.bit_tick && (counter_data_ack_i == COUNT_W'(MASTER_ACK_END_CNT));
    assign end_state  = repeat_start_bit_i ? ST_REPEAT_START : ST_STOP;

    assign ctrl.state = state_q;

    // ------------------------------------------------------------
    // next phase
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:         if (enable_bit_i && ctrl.cond_done) state_d = ST_START;
            ST_START:        if (ctrl.cond_done) state_d = ST_ADDR;
            ST_ADDR:         if (last_bit) state_d = ST_ADDR_ACK;
            ST_ADDR_ACK: begin
                if (ack_sample) begin
                    if (sda_i)
                        state_d = end_state;                     // address nacked
                    else
                        state_d = rw_bit_i ? ST_READ_DATA : ST_WRITE_DATA;
                end
            end
            ST_WRITE_DATA:   if (last_bit) state_d = ST_SLAVE_ACK;
            ST_SLAVE_ACK: begin
                if (ack_sample) begin
                    if (sda_i || trans_fifo_empty_i)
                        state_d = end_state;                     // nack or nothing left to send
                    else
                        state_d = ST_WRITE_DATA;
                end
            end
            ST_READ_DATA:    if (last_bit) state_d = ST_MASTER_ACK;
            ST_MASTER_ACK: begin
                if (mack_end)
                    state_d = rev_fifo_full_i ? end_state : ST_READ_DATA;
            end
            ST_REPEAT_START: if (ctrl.cond_done) state_d = ST_ADDR;
            ST_STOP:         if (ctrl.cond_done) state_d = ST_IDLE;
            default:         state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------
    // fifo strobes, one cycle at the start of each ack slot
    // ------------------------------------------------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            read_fifo_en_o  <= 1'b0;
            write_fifo_en_o <= 1'b0;
        end else begin
            read_fifo_en_o  <= (state_q == ST_WRITE_DATA) && (state_d == ST_SLAVE_ACK);
            write_fifo_en_o <= (state_q == ST_READ_DATA) && (state_d == ST_MASTER_ACK);
        end
    end

    // ------------------------------------------------------------
    // phase strobes and line enables
    // ------------------------------------------------------------
    assign start_cnt_o        = (state_q == ST_START);
    assign write_addr_cnt_o   = (state_q == ST_ADDR);
    assign write_data_cnt_o   = (state_q == ST_WRITE_DATA);
    assign read_data_cnt_o    = (state_q == ST_READ_DATA);
    assign write_ack_cnt_o    = (state_q == ST_MASTER_ACK);
    assign read_ack_cnt_o     = (state_q == ST_ADDR_ACK) || (state_q == ST_SLAVE_ACK);
    assign stop_cnt_o         = (state_q == ST_STOP);
    assign repeat_start_cnt_o = (state_q == ST_REPEAT_START);

    always_comb begin
        case (state_q)
            ST_START, ST_ADDR, ST_WRITE_DATA, ST_MASTER_ACK, ST_REPEAT_START, ST_STOP:
                sda_en_o = 1'b1;
            default:
                sda_en_o = 1'b0;                                 // slave owns sda
        endcase
    end

    always_comb begin
        case (state_q)
            ST_ADDR, ST_ADDR_ACK, ST_WRITE_DATA, ST_READ_DATA, ST_SLAVE_ACK, ST_MASTER_ACK:
                scl_en_o = 1'b1;
            ST_REPEAT_START, ST_STOP:
                scl_en_o = !ctrl.scl_released;                   // scl let go after first tick
            default:
                scl_en_o = 1'b0;
        endcase
    end

endmodule

//--- i2c_ctrl_if.sv
`timescale 1ns/1ps

interface i2c_ctrl_if
    import i2c_master_pkg::*;
#(
    parameter int COUNT_W = 8
);

    i2c_state_e state;         // current phase
    logic       bit_tick;      // edge counter reached the prescaler
    logic       cond_done;     // duration counter expired
    logic       scl_released;  // a tick has passed since state entry

    // the master ack end count (9) needs at least four bits
    if (COUNT_W < 4) begin : g_width_check
        $error("i2c_ctrl_if: COUNT_W must be 4 or more");
    end

    modport fsm_mp (
        output state,
        input  bit_tick,
        input  cond_done,
        input  scl_released
    );

    modport timer_mp (
        input  state,
        output bit_tick,
        output cond_done,
        output scl_released
    );

endinterface

//--- i2c_master_pkg.sv
package i2c_master_pkg;

    // ------------------------------------------------------------
    // phases of one I2C transfer as seen by the control unit
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ST_IDLE         = 4'd0,  // bus free, waiting for enable
        ST_START        = 4'd1,  // start condition
        ST_ADDR         = 4'd2,  // address and r/w bit on sda
        ST_ADDR_ACK     = 4'd3,  // slave acks the address
        ST_WRITE_DATA   = 4'd4,  // master drives a data byte
        ST_READ_DATA    = 4'd5,  // slave drives a data byte
        ST_SLAVE_ACK    = 4'd6,  // slave acks a written byte
        ST_MASTER_ACK   = 4'd7,  // master acks a read byte
        ST_REPEAT_START = 4'd8,  // repeated start condition
        ST_STOP         = 4'd9   // stop condition
    } i2c_state_e;

    // ------------------------------------------------------------
    // bit-slot counter values, the counter runs down from 9
    // ------------------------------------------------------------
    parameter int unsigned LAST_BIT_CNT       = 1;  // last bit of addr or data byte
    parameter int unsigned ACK_SAMPLE_CNT     = 0;  // slave ack is sampled here
    parameter int unsigned MASTER_ACK_END_CNT = 9;  // end of master ack slot

endpackage
